// File: verilog/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int imem_words = 64;
    localparam int dmem_words = 256;
    localparam int a0_index = 10;

    typedef logic [xlen-1:0] word_t;

    // ADDI x0, x0, 0.
    localparam word_t nop_instr = 32'h0000_0013;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_src_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } branch_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc4;
    } fd_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        alu_op_t     alu_op;
        logic        alu_src_b;
        branch_t     branch;
        word_t       pc;
        word_t       pc4;
        word_t       imm;
        word_t       rs1_val;
        word_t       rs2_val;
        logic [4:0]  rd;
    } de_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_t result_src;
        word_t       alu_result;
        word_t       write_data;
        word_t       pc4;
        logic [4:0]  rd;
    } em_t;

    typedef struct packed {
        logic       reg_write;
        logic [4:0] rd;
        word_t      result;
    } mw_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    localparam fd_t fd_bubble = '{instr: nop_instr, pc: '0, pc4: '0};

endpackage

// File: verilog/rv_fetch.sv
module rv_fetch import rv_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  word_t                         imem_data,
    input  redirect_t                     redirect,
    output fd_t                           fd
);

    word_t imem [imem_words];
    word_t pc;
    word_t pc4;
    word_t instr;

    // Program load port.
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign instr = imem[pc[$clog2(imem_words)+1:2]];
    assign pc4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fd <= fd_bubble;
        end else if (redirect.taken) begin
            // Squash whatever was fetched this cycle.
            pc <= redirect.target;
            fd <= fd_bubble;
        end else if (trigger) begin
            pc <= pc4;
            fd <= '{instr: instr, pc: pc, pc4: pc4};
        end else begin
            fd <= fd_bubble;
        end
    end

endmodule

// File: verilog/rv_decode.sv
module rv_decode import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  fd_t       fd,
    input  mw_t       mw,
    input  redirect_t redirect,
    output de_t       de,
    output word_t     a0
);

    word_t      regs [32];
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       wb_en;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    de_t        dec;

    assign opcode = opcode_t'(fd.instr[6:0]);
    assign funct3 = fd.instr[14:12];
    assign funct7 = fd.instr[31:25];
    assign rs1 = fd.instr[19:15];
    assign rs2 = fd.instr[24:20];

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                    fd.instr[30:25], fd.instr[11:8], 1'b0};
    assign imm_u = {fd.instr[31:12], 12'b0};
    assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                    fd.instr[20], fd.instr[30:21], 1'b0};

    // Writes to x0 are dropped.
    assign wb_en = mw.reg_write && (mw.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[mw.rd] <= mw.result;
        end
    end

    // A register being written this cycle is seen by the read.
    assign rs1_val = (wb_en && mw.rd == rs1) ? mw.result : regs[rs1];
    assign rs2_val = (wb_en && mw.rd == rs2) ? mw.result : regs[rs2];

    assign a0 = regs[a0_index];

    always_comb begin
        dec = '0;
        dec.pc = fd.pc;
        dec.pc4 = fd.pc4;
        dec.rs1_val = rs1_val;
        dec.rs2_val = rs2_val;
        dec.rd = fd.instr[11:7];
        case (opcode)
            OPC_OP_IMM: begin
                // Only ADDI is supported.
                dec.reg_write = (funct3 == 3'b000);
                dec.alu_src_b = 1'b1;
                dec.imm = imm_i;
            end
            OPC_OP: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b010: dec.alu_op = ALU_SLT;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec.reg_write = 1'b1;
                dec.alu_op = ALU_PASS_B;
                dec.alu_src_b = 1'b1;
                dec.imm = imm_u;
            end
            OPC_LOAD: begin
                dec.reg_write = 1'b1;
                dec.result_src = RES_MEM;
                dec.alu_src_b = 1'b1;
                dec.imm = imm_i;
            end
            OPC_STORE: begin
                dec.mem_write = 1'b1;
                dec.alu_src_b = 1'b1;
                dec.imm = imm_s;
            end
            OPC_BRANCH: begin
                dec.branch = (funct3 == 3'b001) ? BR_NE : BR_EQ;
                dec.imm = imm_b;
            end
            OPC_JAL: begin
                dec.reg_write = 1'b1;
                dec.result_src = RES_PC4;
                dec.branch = BR_JAL;
                dec.imm = imm_j;
            end
            default: dec.rd = 5'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || redirect.taken) begin
            de <= '0;
        end else begin
            de <= dec;
        end
    end

endmodule

// File: verilog/rv_execute.sv
module rv_execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  de_t       de,
    output em_t       em,
    output redirect_t redirect
);

    word_t b_operand;
    word_t alu_result;
    logic  take;

    assign b_operand = de.alu_src_b ? de.imm : de.rs2_val;

    always_comb begin
        case (de.alu_op)
            ALU_ADD: alu_result = de.rs1_val + b_operand;
            ALU_SUB: alu_result = de.rs1_val - b_operand;
            ALU_AND: alu_result = de.rs1_val & b_operand;
            ALU_OR:  alu_result = de.rs1_val | b_operand;
            ALU_XOR: alu_result = de.rs1_val ^ b_operand;
            ALU_SLT: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(de.rs1_val) < $signed(b_operand)};
            end
            default: alu_result = b_operand;
        endcase
    end

    always_comb begin
        case (de.branch)
            BR_EQ:   take = (de.rs1_val == de.rs2_val);
            BR_NE:   take = (de.rs1_val != de.rs2_val);
            BR_JAL:  take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    // Both branch kinds and JAL are pc relative.
    assign redirect = '{taken: take, target: de.pc + de.imm};

    always_ff @(posedge clk) begin
        if (rst) begin
            em <= '0;
        end else begin
            em <= '{reg_write: de.reg_write, mem_write: de.mem_write,
                    result_src: de.result_src, alu_result: alu_result,
                    write_data: de.rs2_val, pc4: de.pc4, rd: de.rd};
        end
    end

endmodule

// File: verilog/rv_memory.sv
module rv_memory import rv_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  em_t  em,
    output mw_t  mw
);

    word_t                         dmem [dmem_words];
    logic [$clog2(dmem_words)-1:0] index;
    word_t                         result;

    // The low two address bits are ignored.
    assign index = em.alu_result[$clog2(dmem_words)+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (em.mem_write) begin
            dmem[index] <= em.write_data;
        end
    end

    always_comb begin
        case (em.result_src)
            RES_MEM: result = dmem[index];
            RES_PC4: result = em.pc4;
            default: result = em.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw <= '{reg_write: em.reg_write, rd: em.rd, result: result};
        end
    end

endmodule

// File: verilog/rv_core.sv
module rv_core import rv_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          trigger,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  word_t                         imem_data,
    output word_t                         a0
);

    fd_t       fd;
    de_t       de;
    em_t       em;
    mw_t       mw;
    redirect_t redirect;

    rv_fetch rv_fetch_i (
        .clk       (clk),
        .rst       (rst),
        .trigger   (trigger),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .redirect  (redirect),
        .fd        (fd)
    );

    // Writeback closes the loop into the register file held by decode.
    rv_decode rv_decode_i (
        .clk      (clk),
        .rst      (rst),
        .fd       (fd),
        .mw       (mw),
        .redirect (redirect),
        .de       (de),
        .a0       (a0)
    );

    rv_execute rv_execute_i (
        .clk      (clk),
        .rst      (rst),
        .de       (de),
        .em       (em),
        .redirect (redirect)
    );

    rv_memory rv_memory_i (
        .clk (clk),
        .rst (rst),
        .em  (em),
        .mw  (mw)
    );

endmodule

// File: tb/rv_core_sva.sv
module rv_core_sva import rv_pkg::*; (
    input logic      clk,
    input logic      rst,
    input redirect_t redirect,
    input fd_t       fd,
    input de_t       de,
    input em_t       em,
    input mw_t       mw,
    input word_t     a0
);

    int fail_count = 0;

    // No stage may write in the cycle after reset.
    assert property (@(posedge clk) rst |=> !de.reg_write && !de.mem_write
                     && !em.reg_write && !em.mem_write && !mw.reg_write)
        else begin
            $error("stage write enable high after reset");
            fail_count++;
        end

    // Taken branch or jump squashes the fetched instruction.
    assert property (@(posedge clk) !rst && redirect.taken |=> fd == fd_bubble)
        else begin
            $error("fetch register not a bubble after a taken redirect");
            fail_count++;
        end

    assert property (@(posedge clk) !rst |-> !$isunknown(a0))
        else begin
            $error("a0 unknown out of reset");
            fail_count++;
        end

endmodule

// File: tb/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

    localparam int num_tests = 6;
    localparam int prog_words = 16;
    localparam int wait_limit = 200;
    localparam int stable_cycles = 10;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          trigger;
    logic                          imem_we;
    logic [$clog2(imem_words)-1:0] imem_addr;
    word_t                         imem_data;
    word_t                         a0;

    string  test_name [num_tests];
    word_t  prog [num_tests][prog_words];
    word_t  expect_a0 [num_tests];
    int     hold_cycles [num_tests];
    int     errors = 0;
    int     programs_ok = 0;
    integer seed = 32'hf19a;

    rv_core rv_core_i (
        .clk       (clk),
        .rst       (rst),
        .trigger   (trigger),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .a0        (a0)
    );

    bind rv_core rv_core_sva rv_core_sva_i (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .fd       (fd),
        .de       (de),
        .em       (em),
        .mw       (mw),
        .a0       (a0)
    );

    always #10 clk = ~clk;

    function automatic word_t addi_word(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    // Compare failures plus assertion failures from the bound checker.
    function automatic int error_total();
        return errors + rv_core_i.rv_core_sva_i.fail_count;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic build_table();
        logic [11:0] imm1;
        logic [11:0] imm2;
        word_t       a;
        word_t       b;
        word_t       lt;
        imm1 = 12'($random(seed));
        imm2 = 12'($random(seed));
        a = {{20{imm1[11]}}, imm1};
        b = {{20{imm2[11]}}, imm2};
        lt = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        for (int t = 0; t < num_tests; t++) begin
            hold_cycles[t] = 0;
            for (int i = 0; i < prog_words; i++) begin
                prog[t][i] = nop_instr;
            end
        end
        // x4..x6 = add, sub, slt of x1, x2; x7..x9 mix with the LUI in x3.
        test_name[0] = "alu_ops";
        prog[0][0] = addi_word(5'd1, imm1);
        prog[0][1] = addi_word(5'd2, imm2);
        prog[0][2] = 32'hf0f0_f1b7;
        prog[0][4] = 32'h0020_8233;
        prog[0][5] = 32'h4020_82b3;
        prog[0][6] = 32'h0020_a333;
        prog[0][7] = 32'h0032_73b3;
        prog[0][8] = 32'h0032_e433;
        prog[0][9] = 32'h0043_44b3;
        prog[0][11] = 32'h0083_85b3;
        prog[0][14] = 32'h0095_8533;
        prog[0][15] = 32'h0000_006f;
        expect_a0[0] = ((a + b) & 32'hf0f0_f000) + ((a - b) | 32'hf0f0_f000) + (lt ^ (a + b));
        // Stores 0x123 at 8 and -5 at 20 and adds both loads back.
        test_name[1] = "load_store";
        prog[1][0] = 32'h1230_0093;
        prog[1][1] = 32'hffb0_0113;
        prog[1][4] = 32'h0010_2423;
        prog[1][5] = 32'h0020_2a23;
        prog[1][6] = 32'h0080_2283;
        prog[1][7] = 32'h0140_2303;
        prog[1][10] = 32'h0062_8533;
        prog[1][11] = 32'h0000_006f;
        expect_a0[1] = 32'h123 + 32'hffff_fffb;
        // BEQ at slot 4 jumps to slot 8 and the BNE there falls through.
        test_name[2] = "branch_flush";
        prog[2][0] = 32'h0070_0093;
        prog[2][1] = 32'h0070_0113;
        prog[2][2] = 32'h0010_0513;
        prog[2][4] = 32'h0020_8863;
        prog[2][5] = 32'h0550_0513;
        prog[2][6] = 32'h0660_0513;
        prog[2][7] = 32'h0770_0513;
        prog[2][8] = 32'h0020_9863;
        prog[2][9] = 32'h0025_0513;
        prog[2][12] = 32'h0045_0513;
        prog[2][13] = 32'h0000_006f;
        expect_a0[2] = 32'd7;
        // JAL x10, +12 at address 8.
        test_name[3] = "jal_link";
        prog[3][2] = 32'h00c0_056f;
        prog[3][3] = 32'h0550_0513;
        prog[3][4] = 32'h0660_0513;
        prog[3][5] = 32'h0000_006f;
        expect_a0[3] = 32'd8 + 32'd4;
        test_name[4] = "x0_const";
        prog[4][0] = 32'h0550_0013;
        prog[4][1] = 32'habcd_e037;
        prog[4][4] = 32'h0000_0533;
        prog[4][5] = 32'h0210_0593;
        prog[4][8] = 32'h00b5_0533;
        prog[4][9] = 32'h0000_006f;
        expect_a0[4] = 32'h21;
        test_name[5] = "trigger_hold";
        prog[5][0] = 32'h02a0_0513;
        prog[5][1] = 32'h0000_006f;
        hold_cycles[5] = 50;
        expect_a0[5] = 32'h2a;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < prog_words; i++) begin
            imem_we = 1'b1;
            imem_addr = 6'(i);
            imem_data = prog[t][i];
            next_cycle();
        end
        imem_we = 1'b0;
    endtask

    task automatic wait_for_a0(input word_t expected, output logic hit);
        int cycles;
        cycles = 0;
        while (a0 !== expected && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        hit = (a0 === expected);
    endtask

    task automatic run_test(input int t);
        int   errors_before;
        logic hit;
        errors_before = error_total();
        rst = 1'b1;
        trigger = 1'b0;
        load_program(t);
        rst = 1'b0;
        // Nothing may retire while fetch is idle.
        repeat (hold_cycles[t]) begin
            next_cycle();
            check_word("a0", a0, '0);
        end
        trigger = 1'b1;
        wait_for_a0(expect_a0[t], hit);
        if (!hit) begin
            $display("Timeout: a0 did not reach %h within %0d cycles", expect_a0[t], wait_limit);
            errors++;
        end
        repeat (stable_cycles) begin
            next_cycle();
            check_word("a0", a0, expect_a0[t]);
        end
        if (error_total() == errors_before) begin
            programs_ok++;
            $display("%s: ok", test_name[t]);
        end else begin
            $display("%s: %0d errors", test_name[t], error_total() - errors_before);
        end
    endtask

    initial begin
        rst = 1'b1;
        trigger = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d of %0d programs ok, %0d errors, %0d assertion failures",
                 programs_ok, num_tests, errors, rv_core_i.rv_core_sva_i.fail_count);
        if (error_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rv_core_tb
FILELIST := tb.f
OBJ      := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)
